// File: verilog/imu_cfg.svh
// Sensor timing, register map and configuration values
// Millisecond prescale is reduced so that simulation stays short

`ifndef IMU_CFG_SVH
`define IMU_CFG_SVH

`define IMU_CLKS_PER_MS       20      // sys_clk cycles per ms, 12000 on the board
`define IMU_BOOT_MS           5       // Power-on boot time of the sensor
`define IMU_RUN_MODE_MS       20      // Config to NDOF switch settling
`define IMU_POLL_MS           20      // Poll and frame period, 50 Hz

`define IMU_BURST_LEN         24      // Accel, mag, gyro, euler, 2 bytes x 3 axes each
`define IMU_BURST_START_ADDR  8'h08   // ACC_DATA_X_LSB

`define IMU_REG_UNIT_SEL      8'h3B
`define IMU_VAL_UNIT_SEL      8'h80   // Android orientation, degC, deg, dps, m/s^2
`define IMU_REG_PWR_MODE      8'h3E
`define IMU_VAL_PWR_NORMAL    8'h00
`define IMU_REG_SYS_TRIGGER   8'h3F
`define IMU_VAL_EXT_CRYSTAL   8'h80   // CLK_SEL bit
`define IMU_REG_OPR_MODE      8'h3D
`define IMU_VAL_OPR_NDOF      8'h0C   // Nine-axis fusion

`endif

// File: verilog/imu_pkg.sv
// Vector types and sequencer state encoding for the BNO055 sequencer

`default_nettype none

package imu_pkg;

	typedef logic [7:0]  reg_addr_t;  // Sensor register address
	typedef logic [7:0]  reg_byte_t;  // One register data byte
	typedef logic [15:0] sample_t;    // Raw signed word, {MSB, LSB}
	typedef logic [15:0] ms_count_t;  // Millisecond or prescale count
	typedef logic [4:0]  burst_idx_t; // Byte index into a burst

	// Sequencer control states
	typedef enum logic [3:0] {
		BOOT_WAIT,     // Sensor boot delay
		CFG_ISSUE,     // Raise request for next config write
		CFG_WAIT_ACK,  // Write in flight
		CFG_RELEASE,   // Wait for ack to drop
		RUN_WAIT,      // NDOF settling
		POLL_ISSUE,    // Raise burst read request
		POLL_WAIT_ACK, // Burst in flight
		POLL_RELEASE,  // Wait for ack to drop
		POLL_IDLE      // Wait for poll period to expire
	} seq_state_t;

endpackage

`default_nettype wire

// File: verilog/imu_if.sv
// Timer control interface and receive burst interface

`default_nettype none

interface ms_timer_if;
	logic                load;    // One-cycle load strobe
	imu_pkg::ms_count_t  wait_ms; // Count captured on load
	logic                done;    // Level, count expired
	logic                ms_tick; // One pulse per ms

	modport ctl (
		output load,
		output wait_ms,
		input  done
	);

	modport tmr (
		input  load,
		input  wait_ms,
		output done,
		output ms_tick
	);

	modport tick (
		input  ms_tick
	);
endinterface

interface rx_burst_if;
	logic                byte_valid; // Received byte strobe
	imu_pkg::reg_byte_t  byte_data;  // Received byte
	logic                clear;      // Restart byte index
	logic                latch;      // Copy buffer to outputs

	modport seq (output clear, output latch);

	modport rx_buf (input byte_valid, input byte_data, input clear, input latch);
endinterface

`default_nettype wire

// File: verilog/ms_timer.sv
// Free-running ms prescaler and loadable ms countdown

`default_nettype none
`include "imu_cfg.svh"

module ms_timer (
	input  wire      sys_clk,
	input  wire      rstn,
	ms_timer_if.tmr  tmr
);

	imu_pkg::ms_count_t pre_cnt; // Cycles into the current ms
	imu_pkg::ms_count_t ms_left; // Ticks still to go

	// Prescaler, never restarted so the frame timer sees a steady tick
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			pre_cnt     <= '0;
			tmr.ms_tick <= 1'b0;
		end else if (pre_cnt == imu_pkg::ms_count_t'(`IMU_CLKS_PER_MS - 1)) begin
			pre_cnt     <= '0;
			tmr.ms_tick <= 1'b1; // Wrap, one tick
		end else begin
			pre_cnt     <= pre_cnt + 16'd1;
			tmr.ms_tick <= 1'b0;
		end
	end

	// Extra tick on load so a partial first ms is never counted as whole
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			ms_left  <= '0;
			tmr.done <= 1'b0;
		end else if (tmr.load) begin
			ms_left  <= tmr.wait_ms + 16'd1;
			tmr.done <= 1'b0; // Cleared in the load edge, never stale
		end else begin
			if (tmr.ms_tick && ms_left != '0)
				ms_left <= ms_left - 16'd1;
			if (ms_left == '0)
				tmr.done <= 1'b1; // Sticky until next load
		end
	end

endmodule

`default_nettype wire

// File: verilog/imu_sequencer.sv
// BNO055 control FSM: boot wait, four config writes, then periodic burst reads
// Drives the four-phase req/ack bus port and the sample latch

`default_nettype none
`include "imu_cfg.svh"

module imu_sequencer (
	input  wire                      sys_clk,
	input  wire                      rstn,
	ms_timer_if.ctl                  tmr,
	rx_burst_if.seq                  rx,
	output logic                     bus_req,
	output logic                     bus_rw,    // 1 = read
	output imu_pkg::reg_addr_t       bus_reg,
	output imu_pkg::reg_byte_t       bus_wdata,
	output imu_pkg::burst_idx_t      bus_len,
	input  wire                      bus_ack,
	output logic                     imu_good
);

	imu_pkg::seq_state_t state;
	logic [1:0]          cfg_idx;    // Config table entry
	logic                boot_armed; // Boot wait already loaded
	imu_pkg::reg_addr_t  cfg_reg;
	imu_pkg::reg_byte_t  cfg_val;

	// Config table, written in this order
	always_comb begin
		case (cfg_idx)
			2'd0:    begin cfg_reg = `IMU_REG_UNIT_SEL;    cfg_val = `IMU_VAL_UNIT_SEL;    end
			2'd1:    begin cfg_reg = `IMU_REG_PWR_MODE;    cfg_val = `IMU_VAL_PWR_NORMAL;  end
			2'd2:    begin cfg_reg = `IMU_REG_SYS_TRIGGER; cfg_val = `IMU_VAL_EXT_CRYSTAL; end
			default: begin cfg_reg = `IMU_REG_OPR_MODE;    cfg_val = `IMU_VAL_OPR_NDOF;    end
		endcase
	end

	// Timer loads land on the same edge as the state change
	always_comb begin
		tmr.load    = 1'b0;
		tmr.wait_ms = imu_pkg::ms_count_t'(`IMU_POLL_MS);
		rx.clear    = 1'b0;
		case (state)
			imu_pkg::BOOT_WAIT: begin
				tmr.load    = !boot_armed;
				tmr.wait_ms = imu_pkg::ms_count_t'(`IMU_BOOT_MS);
			end
			imu_pkg::CFG_WAIT_ACK: begin
				tmr.load    = bus_ack && cfg_idx == 2'd3; // Settling starts at last ack
				tmr.wait_ms = imu_pkg::ms_count_t'(`IMU_RUN_MODE_MS);
			end
			imu_pkg::POLL_ISSUE: begin
				tmr.load = 1'b1; // Poll period, loaded as req rises
				rx.clear = 1'b1; // Fresh byte index for this burst
			end
			default: ;
		endcase
	end

	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			state      <= imu_pkg::BOOT_WAIT;
			cfg_idx    <= 2'd0;
			boot_armed <= 1'b0;
			bus_req    <= 1'b0;
			bus_rw     <= 1'b0;
			bus_reg    <= '0;
			bus_wdata  <= '0;
			bus_len    <= '0;
			rx.latch   <= 1'b0;
			imu_good   <= 1'b0;
		end else begin
			rx.latch <= 1'b0;
			if (rx.latch)
				imu_good <= 1'b1; // Rises with the first output update
			case (state)
				imu_pkg::BOOT_WAIT: begin
					boot_armed <= 1'b1;
					if (boot_armed && tmr.done && !bus_ack)
						state <= imu_pkg::CFG_ISSUE;
				end
				imu_pkg::CFG_ISSUE: begin
					bus_req   <= 1'b1; // Fields settle with req
					bus_rw    <= 1'b0;
					bus_reg   <= cfg_reg;
					bus_wdata <= cfg_val;
					bus_len   <= imu_pkg::burst_idx_t'(1);
					state     <= imu_pkg::CFG_WAIT_ACK;
				end
				imu_pkg::CFG_WAIT_ACK: begin
					if (bus_ack) begin
						bus_req <= 1'b0;
						state   <= imu_pkg::CFG_RELEASE;
					end
				end
				imu_pkg::CFG_RELEASE: begin
					if (!bus_ack) begin
						cfg_idx <= cfg_idx + 2'd1;
						state   <= (cfg_idx == 2'd3) ? imu_pkg::RUN_WAIT : imu_pkg::CFG_ISSUE;
					end
				end
				imu_pkg::RUN_WAIT: begin
					if (tmr.done)
						state <= imu_pkg::POLL_ISSUE;
				end
				imu_pkg::POLL_ISSUE: begin
					bus_req   <= 1'b1;
					bus_rw    <= 1'b1;
					bus_reg   <= `IMU_BURST_START_ADDR;
					bus_wdata <= '0;
					bus_len   <= imu_pkg::burst_idx_t'(`IMU_BURST_LEN);
					state     <= imu_pkg::POLL_WAIT_ACK;
				end
				imu_pkg::POLL_WAIT_ACK: begin
					if (bus_ack) begin // All bytes delivered by now
						bus_req  <= 1'b0;
						rx.latch <= 1'b1;
						state    <= imu_pkg::POLL_RELEASE;
					end
				end
				imu_pkg::POLL_RELEASE: begin
					if (!bus_ack)
						state <= imu_pkg::POLL_IDLE;
				end
				imu_pkg::POLL_IDLE: begin
					if (tmr.done)
						state <= imu_pkg::POLL_ISSUE;
				end
				default: state <= imu_pkg::BOOT_WAIT;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/sample_regs.sv
// Burst receive buffer and the twelve latched measurement registers

`default_nettype none
`include "imu_cfg.svh"

module sample_regs (
	input  wire                 sys_clk,
	input  wire                 rstn,
	rx_burst_if.rx_buf          rx,
	output imu_pkg::sample_t    accel_x,
	output imu_pkg::sample_t    accel_y,
	output imu_pkg::sample_t    accel_z,
	output imu_pkg::sample_t    mag_x,
	output imu_pkg::sample_t    mag_y,
	output imu_pkg::sample_t    mag_z,
	output imu_pkg::sample_t    gyro_x,
	output imu_pkg::sample_t    gyro_y,
	output imu_pkg::sample_t    gyro_z,
	output imu_pkg::sample_t    euler_x,
	output imu_pkg::sample_t    euler_y,
	output imu_pkg::sample_t    euler_z
);

	imu_pkg::reg_byte_t  rx_bytes [`IMU_BURST_LEN]; // Raw burst, register order
	imu_pkg::burst_idx_t wr_idx;                    // Next byte slot
	imu_pkg::sample_t    meas [12];                 // Latched words
	logic                room;                      // Slot still free

	assign room = wr_idx < imu_pkg::burst_idx_t'(`IMU_BURST_LEN); // Extra bytes dropped

	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn)
			wr_idx <= '0;
		else if (rx.clear)
			wr_idx <= '0; // Synchronous restart per burst
		else if (rx.byte_valid && room)
			wr_idx <= wr_idx + 5'd1;
	end

	always_ff @(posedge sys_clk) begin
		if (rx.byte_valid && room && !rx.clear)
			rx_bytes[wr_idx] <= rx.byte_data;
	end

	// Sensor stores LSB first, word k is {byte 2k+1, byte 2k}
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			for (int k = 0; k < 12; k++)
				meas[k] <= '0;
		end else if (rx.latch) begin
			for (int k = 0; k < 12; k++)
				meas[k] <= {rx_bytes[2*k+1], rx_bytes[2*k]};
		end
	end

	assign accel_x = meas[0];
	assign accel_y = meas[1];
	assign accel_z = meas[2];
	assign mag_x   = meas[3];
	assign mag_y   = meas[4];
	assign mag_z   = meas[5];
	assign gyro_x  = meas[6];
	assign gyro_y  = meas[7];
	assign gyro_z  = meas[8];
	assign euler_x = meas[9];  // Heading
	assign euler_y = meas[10]; // Roll
	assign euler_z = meas[11]; // Pitch

endmodule

`default_nettype wire

// File: verilog/valid_strobe_gen.sv
// Frame timer and valid_strobe held until the consumer answers

`default_nettype none
`include "imu_cfg.svh"

module valid_strobe_gen (
	input  wire       sys_clk,
	input  wire       rstn,
	ms_timer_if.tick  tick,
	input  wire       latch_busy,   // Outputs updating this cycle
	input  wire       ac_active,
	output logic      valid_strobe
);

	imu_pkg::ms_count_t frame_ms; // ms left in frame
	logic               expired;  // Frame end this cycle
	logic               pend;     // Expiry deferred past a latch
	logic               fire;

	assign expired = tick.ms_tick && frame_ms == 16'd1;
	assign fire    = (expired || pend) && !latch_busy;

	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			frame_ms     <= imu_pkg::ms_count_t'(`IMU_POLL_MS);
			pend         <= 1'b0;
			valid_strobe <= 1'b0;
		end else begin
			if (expired)
				frame_ms <= imu_pkg::ms_count_t'(`IMU_POLL_MS); // Reload, steady period
			else if (tick.ms_tick)
				frame_ms <= frame_ms - 16'd1;
			pend         <= (expired || pend) && latch_busy; // Hold one cycle
			valid_strobe <= fire || (valid_strobe && !ac_active);
		end
	end

endmodule

`default_nettype wire

// File: verilog/imu_bno055.sv
// Top level of the BNO055 sequencer
// Timer, FSM, sample registers and frame strobe around the bus port

`default_nettype none

module imu_bno055 (
	input  wire                      sys_clk,
	input  wire                      rstn,
	output logic                     bus_req,
	output logic                     bus_rw,
	output imu_pkg::reg_addr_t       bus_reg,
	output imu_pkg::reg_byte_t       bus_wdata,
	output imu_pkg::burst_idx_t      bus_len,
	input  wire                      bus_ack,
	input  wire                      rx_valid,  // One pulse per received byte
	input  imu_pkg::reg_byte_t       rx_data,
	input  wire                      ac_active, // Consumer took the frame
	output logic                     imu_good,
	output logic                     valid_strobe,
	output imu_pkg::sample_t         accel_x,
	output imu_pkg::sample_t         accel_y,
	output imu_pkg::sample_t         accel_z,
	output imu_pkg::sample_t         mag_x,
	output imu_pkg::sample_t         mag_y,
	output imu_pkg::sample_t         mag_z,
	output imu_pkg::sample_t         gyro_x,
	output imu_pkg::sample_t         gyro_y,
	output imu_pkg::sample_t         gyro_z,
	output imu_pkg::sample_t         euler_x,
	output imu_pkg::sample_t         euler_y,
	output imu_pkg::sample_t         euler_z
);

	ms_timer_if tmr_if ();
	rx_burst_if rx_if ();

	assign rx_if.byte_valid = rx_valid;
	assign rx_if.byte_data  = rx_data;

	ms_timer u_ms_timer (
		.sys_clk (sys_clk),
		.rstn    (rstn),
		.tmr     (tmr_if.tmr)
	);

	imu_sequencer u_sequencer (
		.sys_clk   (sys_clk),
		.rstn      (rstn),
		.tmr       (tmr_if.ctl),
		.rx        (rx_if.seq),
		.bus_req   (bus_req),
		.bus_rw    (bus_rw),
		.bus_reg   (bus_reg),
		.bus_wdata (bus_wdata),
		.bus_len   (bus_len),
		.bus_ack   (bus_ack),
		.imu_good  (imu_good)
	);

	sample_regs u_sample_regs (
		.sys_clk (sys_clk),
		.rstn    (rstn),
		.rx      (rx_if.rx_buf),
		.accel_x (accel_x),
		.accel_y (accel_y),
		.accel_z (accel_z),
		.mag_x   (mag_x),
		.mag_y   (mag_y),
		.mag_z   (mag_z),
		.gyro_x  (gyro_x),
		.gyro_y  (gyro_y),
		.gyro_z  (gyro_z),
		.euler_x (euler_x),
		.euler_y (euler_y),
		.euler_z (euler_z)
	);

	valid_strobe_gen u_valid_strobe (
		.sys_clk      (sys_clk),
		.rstn         (rstn),
		.tick         (tmr_if.tick),
		.latch_busy   (rx_if.latch), // Frame end waits out an output update
		.ac_active    (ac_active),
		.valid_strobe (valid_strobe)
	);

endmodule

`default_nettype wire

// File: verification/imu_checker.sv
// Monitor for the BNO055 sequencer testbench
// Checks reset state, config order, bus handshake, sample words and valid_strobe hold

`default_nettype none
`include "imu_cfg.svh"

module imu_checker (
	input  wire          sys_clk,
	input  wire          rstn,
	input  wire          bus_req,
	input  wire          bus_rw,
	input  wire [7:0]    bus_reg,
	input  wire [7:0]    bus_wdata,
	input  wire [4:0]    bus_len,
	input  wire          bus_ack,
	input  wire          rx_valid,
	input  wire [7:0]    rx_data,
	input  wire          ac_active,
	input  wire          imu_good,
	input  wire          valid_strobe,
	input  wire [191:0]  samples,        // Word k at [16k +: 16], accel_x is word 0
	input  wire          finish_run,     // Stimulus over, print the summary
	input  wire          run_timeout,
	output int           bursts_checked,
	output int           err_total,
	output logic         report_done
);

	localparam int BOOT_CYCLES = `IMU_BOOT_MS * `IMU_CLKS_PER_MS;   // Earliest first request
	localparam int MIN_GAP     = `IMU_POLL_MS * `IMU_CLKS_PER_MS - 1; // Strobe rise spacing

	logic [7:0]  burst_bytes [`IMU_BURST_LEN]; // Bytes the master sent this burst
	logic [21:0] fields_q;                     // {rw, reg, wdata, len} at req rise
	logic        req_q = 1'b0;
	logic        ack_q = 1'b0;
	logic        vs_q = 1'b0;
	logic        ac_q = 1'b0;
	logic        reset_done = 1'b0;
	logic        good_seen = 1'b0;             // First latch passed
	int          cyc = 0;
	int          since_rst = 0;
	int          cfg_cnt = 0;
	int          byte_cnt = 0;
	int          smp_wait = 0;                 // Cycles until outputs are due
	int          vs_rises = 0;
	int          last_rise = 0;
	int          err_reset = 0;
	int          err_cfg = 0;
	int          err_hs = 0;
	int          err_smp = 0;
	int          err_vld = 0;
	int          err_to = 0;
	int          n_pass = 0;
	int          n_fail = 0;

	// Register and value of config write idx, in issue order
	function automatic logic [15:0] cfg_entry(input int idx);
		case (idx)
			0:       return {`IMU_REG_UNIT_SEL, `IMU_VAL_UNIT_SEL};
			1:       return {`IMU_REG_PWR_MODE, `IMU_VAL_PWR_NORMAL};
			2:       return {`IMU_REG_SYS_TRIGGER, `IMU_VAL_EXT_CRYSTAL};
			default: return {`IMU_REG_OPR_MODE, `IMU_VAL_OPR_NDOF};
		endcase
	endfunction

	function automatic int check_equal(input string test, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		if (expected === actual)
			return 0;
		$display("mismatch %s %s: expected %0h, actual %0h", test, what, expected, actual);
		return 1;
	endfunction

	task automatic report_result(input string name, input int errs);
		if (errs == 0) begin
			n_pass++;
			$display("test %s: passed", name);
		end else begin
			n_fail++;
			$display("test %s: failed with %0d errors", name, errs);
		end
	endtask

	// All inputs are read as they stood before the edge
	always @(posedge sys_clk) begin : watch
		logic [15:0] entry;
		logic [15:0] want;
		if (!rstn) begin
			bursts_checked = 0;
			err_total      = 0;
			report_done    = 1'b0;
		end else begin
			cyc++;
			if (!reset_done) begin
				if (since_rst == 0) begin // First cycle out of reset
					err_reset += check_equal("reset_state", "bus_req", 0, 32'(bus_req));
					err_reset += check_equal("reset_state", "imu_good", 0, 32'(imu_good));
					err_reset += check_equal("reset_state", "valid_strobe", 0, 32'(valid_strobe));
					for (int k = 0; k < 12; k++)
						err_reset += check_equal("reset_state", $sformatf("word %0d", k), 0,
							32'(samples[16*k +: 16]));
				end
				if (bus_req) begin
					if (since_rst < BOOT_CYCLES) begin
						$display("reset_state: bus_req rose %0d cycles after reset, before boot",
							since_rst);
						err_reset++;
					end
					reset_done = 1'b1;
					report_result("reset_state", err_reset);
				end
				since_rst++;
			end
			if (bus_req && !req_q) begin // New request
				if (bus_ack) begin
					$display("handshake_rule: bus_req rose while bus_ack was still high");
					err_hs++;
				end
				if (cfg_cnt < 4) begin
					entry = cfg_entry(cfg_cnt);
					err_cfg += check_equal("config_sequence", "bus_rw", 0, 32'(bus_rw));
					err_cfg += check_equal("config_sequence", "bus_reg", 32'(entry[15:8]),
						32'(bus_reg));
					err_cfg += check_equal("config_sequence", "bus_wdata", 32'(entry[7:0]),
						32'(bus_wdata));
					cfg_cnt++;
					if (cfg_cnt == 4)
						report_result("config_sequence", err_cfg);
				end else begin
					err_smp += check_equal("sample_assembly", "bus_rw", 1, 32'(bus_rw));
					err_smp += check_equal("sample_assembly", "bus_reg", `IMU_BURST_START_ADDR,
						32'(bus_reg));
					err_smp += check_equal("sample_assembly", "bus_len", `IMU_BURST_LEN,
						32'(bus_len));
				end
				byte_cnt = 0;
				fields_q = {bus_rw, bus_reg, bus_wdata, bus_len};
			end
			if (bus_req && req_q && {bus_rw, bus_reg, bus_wdata, bus_len} != fields_q) begin
				$display("handshake_rule: request fields changed while bus_req was high");
				err_hs++;
			end
			if (!bus_req && req_q && !ack_q) begin
				$display("handshake_rule: bus_req fell before bus_ack rose");
				err_hs++;
			end
			if (rx_valid && byte_cnt < `IMU_BURST_LEN) begin
				burst_bytes[byte_cnt] = rx_data;
				byte_cnt++;
			end
			if (smp_wait == 1) begin // One cycle after latch
				for (int k = 0; k < 12; k++) begin
					want = {burst_bytes[2*k+1], burst_bytes[2*k]};
					err_smp += check_equal("sample_assembly", $sformatf("word %0d", k),
						32'(want), 32'(samples[16*k +: 16]));
				end
				good_seen = 1'b1;
				bursts_checked++;
			end
			if (smp_wait > 0)
				smp_wait--;
			if (good_seen)
				err_smp += check_equal("sample_assembly", "imu_good", 1, 32'(imu_good));
			else
				err_smp += check_equal("sample_assembly", "imu_good", 0, 32'(imu_good));
			if (bus_req && bus_ack && bus_rw)
				smp_wait = 2; // DUT sees the read ack, latch follows
			if (valid_strobe && !vs_q) begin
				if (vs_rises > 0 && cyc - last_rise < MIN_GAP) begin
					$display("valid_hold: valid_strobe rose %0d cycles after the previous rise",
						cyc - last_rise);
					err_vld++;
				end
				vs_rises++;
				last_rise = cyc;
			end
			if (vs_q && ac_q && valid_strobe) begin
				$display("valid_hold: valid_strobe stayed high after ac_active was seen");
				err_vld++;
			end
			if (vs_q && !ac_q && !valid_strobe) begin
				$display("valid_hold: valid_strobe fell before ac_active was seen");
				err_vld++;
			end
			req_q = bus_req;
			ack_q = bus_ack;
			vs_q  = valid_strobe;
			ac_q  = ac_active;
			if (finish_run && !report_done) begin
				if (!reset_done) begin
					$display("reset_state: bus_req never rose");
					report_result("reset_state", err_reset + 1);
					err_reset++;
				end
				if (cfg_cnt < 4) begin
					$display("config_sequence: only %0d config writes were seen", cfg_cnt);
					report_result("config_sequence", err_cfg + 1);
					err_cfg++;
				end
				report_result("handshake_rule", err_hs);
				report_result("sample_assembly", err_smp);
				if (vs_rises < 2) begin
					$display("valid_hold: only %0d valid_strobe pulses were seen", vs_rises);
					err_vld++;
				end
				report_result("valid_hold", err_vld);
				if (run_timeout) begin
					$display("timeout: run stopped after %0d cycles with %0d bursts checked",
						cyc, bursts_checked);
					err_to = 1;
				end
				err_total = err_reset + err_cfg + err_hs + err_smp + err_vld + err_to;
				$display("summary: %0d tests passed, %0d failed, %0d errors",
					n_pass, n_fail, err_total);
				report_done = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verification/tb_imu_bno055.sv
// Testbench top for the BNO055 sequencer
// Clock and reset, LCG-driven bus master, ac_active consumer and run timeout

`default_nettype none
`include "imu_cfg.svh"

module tb_imu_bno055;

	localparam logic [31:0] SEED = 32'hc8997b9c;
	localparam int BURSTS = 6; // Latched bursts before the run ends
	// Boot, run wait and six polls at the ms prescale, margin for ack delays
	localparam int TIMEOUT_CYCLES =
		(`IMU_BOOT_MS + `IMU_RUN_MODE_MS + BURSTS * `IMU_POLL_MS) * `IMU_CLKS_PER_MS + 1100;

	logic                sys_clk;
	logic                rstn;
	logic                bus_req;
	logic                bus_rw;
	imu_pkg::reg_addr_t  bus_reg;
	imu_pkg::reg_byte_t  bus_wdata;
	imu_pkg::burst_idx_t bus_len;
	logic                bus_ack;
	logic                rx_valid;
	imu_pkg::reg_byte_t  rx_data;
	logic                ac_active;
	logic                imu_good;
	logic                valid_strobe;
	imu_pkg::sample_t    accel_x, accel_y, accel_z;
	imu_pkg::sample_t    mag_x, mag_y, mag_z;
	imu_pkg::sample_t    gyro_x, gyro_y, gyro_z;
	imu_pkg::sample_t    euler_x, euler_y, euler_z;
	logic                finish_run;  // Stimulus over
	logic                run_timeout;
	logic                report_done; // Checker summary printed
	int                  bursts_checked;
	int                  err_total;
	int                  cycle_cnt = 0;

	// Numerical Recipes LCG step
	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int draw_below(input logic [31:0] state, input int n);
		return int'(state[31:16]) % n; // Upper bits, better spread
	endfunction

	imu_bno055 DUT (.*);

	imu_checker u_checker (
		.*,
		.samples ({euler_z, euler_y, euler_x, gyro_z, gyro_y, gyro_x,
			mag_z, mag_y, mag_x, accel_z, accel_y, accel_x}) // accel_x in the low word
	);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	always @(posedge sys_clk)
		cycle_cnt <= cycle_cnt + 1;

	initial begin : main
		rstn        = 1'b0;
		finish_run  = 1'b0;
		run_timeout = 1'b0;
		repeat (10) @(negedge sys_clk);
		rstn = 1'b1;
		while (bursts_checked < BURSTS && cycle_cnt < TIMEOUT_CYCLES)
			@(negedge sys_clk);
		run_timeout = bursts_checked < BURSTS;
		finish_run  = 1'b1;
		while (!report_done)
			@(negedge sys_clk);
		if (err_total == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// Bus master, four-phase, answers on the falling edge
	initial begin : bus_master
		logic [31:0] seed;
		int          delay;
		int          gap;
		seed     = SEED;
		bus_ack  = 1'b0;
		rx_valid = 1'b0;
		rx_data  = '0;
		@(posedge rstn);
		forever begin
			@(negedge sys_clk);
			if (bus_req && !bus_ack) begin
				seed  = lcg_next(seed);
				delay = 1 + draw_below(seed, 40); // Ack delay 1 to 40
				repeat (delay) @(negedge sys_clk);
				if (bus_rw) begin
					for (int i = 0; i < int'(bus_len); i++) begin
						seed = lcg_next(seed);
						gap  = draw_below(seed, 4);
						repeat (gap) @(negedge sys_clk);
						seed     = lcg_next(seed);
						rx_valid = 1'b1;
						rx_data  = 8'(draw_below(seed, 256));
						@(negedge sys_clk);
						rx_valid = 1'b0;
					end
				end
				bus_ack = 1'b1;
				while (bus_req)
					@(negedge sys_clk); // Hold until req drops
				bus_ack = 1'b0;
			end
		end
	end

	// Consumer answers valid_strobe after 0 to 15 cycles
	initial begin : consumer
		logic [31:0] seed;
		int          lag;
		seed      = SEED;
		ac_active = 1'b0;
		@(posedge rstn);
		forever begin
			@(negedge sys_clk);
			if (valid_strobe && !ac_active) begin
				seed = lcg_next(seed);
				lag  = draw_below(seed, 16);
				repeat (lag) @(negedge sys_clk);
				ac_active = 1'b1;
				while (valid_strobe)
					@(negedge sys_clk);
				ac_active = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: imu_bno055.f
+incdir+verilog
verilog/imu_pkg.sv
verilog/imu_if.sv
verilog/ms_timer.sv
verilog/imu_sequencer.sv
verilog/sample_regs.sv
verilog/valid_strobe_gen.sv
verilog/imu_bno055.sv
verification/imu_checker.sv
verification/tb_imu_bno055.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator, exit status follows the result
cd "$(dirname "$0")" &&
	verilator --binary --timing --top-module tb_imu_bno055 -f imu_bno055.f -o sim_imu_bno055 &&
	./obj_dir/sim_imu_bno055 | tee /dev/stderr | grep -F "*** TEST PASSED ***" > /dev/null &&
	echo "run_sim: simulation passed" ||
	{ echo "run_sim: simulation failed"; exit 1; }
